/* all.f */
hdl/ex_pkg.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/mult_stage.sv
hdl/mult.sv
hdl/complete_queue.sv
hdl/ex_stage.sv
verif/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ex_stage_tb -f all.f

out=$(./obj_dir/Vex_stage_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

/* verif/ex_stage_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the execute stage with two issue slots
// a table of instructions with random operands and a few fixed edge
// cases is issued pair by pair, and each result is looked up by its
// tag and compared with a model of the RV32IM rules
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage_tb;

	localparam int N_WAY       = 2;
	localparam int MULT_STAGES = 4;
	localparam int Q_DEPTH     = 8;
	localparam int N_INST      = 48;
	localparam int N_ROWS      = N_INST / N_WAY;
	localparam int TIMEOUT_NS  = N_ROWS * (MULT_STAGES + Q_DEPTH) * 20;

	logic                clock;
	logic                reset;
	ex_pkg::issue_slot_t issue    [N_WAY];
	logic                issue_ready;
	ex_pkg::complete_t   complete [N_WAY];
	logic [N_WAY-1:0]    reg_wr_en;
	logic                complete_ready;

	ex_pkg::issue_slot_t stim [$];       // issue order with two per row
	ex_pkg::complete_t   expected [64];  // by tag
	bit                  tag_used [64];
	int                  seen [64];
	ex_pkg::xlen_t       rng_state = 30;
	int                  row, reserved, distinct;
	int                  value_errors, other_errors;
	bit                  stall_seen;

	ex_stage #(
		.N_WAY      (N_WAY),
		.MULT_STAGES(MULT_STAGES),
		.Q_DEPTH    (Q_DEPTH)
	) ex_stage_i (
		.clock         (clock),
		.reset         (reset),
		.issue         (issue),
		.issue_ready   (issue_ready),
		.complete      (complete),
		.reg_wr_en     (reg_wr_en),
		.complete_ready(complete_ready)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired with %0d of %0d results seen", distinct, N_INST);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus generation and reference model

	function automatic ex_pkg::xlen_t next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic ex_pkg::xlen_t sign_extend(input ex_pkg::xlen_t v, input int bits);
		return ex_pkg::xlen_t'($signed(v << (32 - bits)) >>> (32 - bits));
	endfunction

	function automatic ex_pkg::issue_slot_t random_slot(input ex_pkg::exec_unit_e unit);
		ex_pkg::issue_slot_t s;
		s           = '0;
		s.valid     = 1'b1;
		s.unit      = unit;
		s.inst      = next_random();
		s.pc        = next_random() & 32'hffff_fffc;
		s.npc       = s.pc + 32'd4;
		s.rs1_value = next_random();
		s.rs2_value = next_random();
		s.dest_tag  = ex_pkg::tag_t'(stim.size() + 1);
		return s;
	endfunction

	function automatic ex_pkg::complete_t model(input ex_pkg::issue_slot_t s);
		ex_pkg::complete_t e;
		ex_pkg::xlen_t     a, b, v;
		ex_pkg::inst_t     w;
		longint            x, y, p;
		logic              c;
		w          = s.inst;
		e          = '0;
		e.valid    = 1'b1;
		e.dest_tag = s.dest_tag;
		case (s.opa_sel)
			ex_pkg::OPA_IS_RS1: a = s.rs1_value;
			ex_pkg::OPA_IS_NPC: a = s.npc;
			ex_pkg::OPA_IS_PC:  a = s.pc;
			default:            a = 32'd0;
		endcase
		case (s.opb_sel)
			ex_pkg::OPB_IS_I_IMM: b = sign_extend(32'(w[31:20]), 12);
			ex_pkg::OPB_IS_S_IMM: b = sign_extend(32'({w[31:25], w[11:7]}), 12);
			ex_pkg::OPB_IS_B_IMM:
				b = sign_extend(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
			ex_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'h000};
			ex_pkg::OPB_IS_J_IMM:
				b = sign_extend(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
			default:              b = s.rs2_value;
		endcase
		if (s.unit == ex_pkg::UNIT_MULT) begin
			if (s.mult_func == ex_pkg::MULHU)
				x = longint'({32'b0, s.rs1_value});
			else
				x = longint'($signed(s.rs1_value));
			if (s.mult_func == ex_pkg::MULHU || s.mult_func == ex_pkg::MULHSU)
				y = longint'({32'b0, s.rs2_value});
			else
				y = longint'($signed(s.rs2_value));
			p        = x * y;
			e.result = (s.mult_func == ex_pkg::MUL) ? p[31:0] : p[63:32];
		end else if (s.unit == ex_pkg::UNIT_BRANCH) begin
			case (w[14:12])
				3'b000:  c = s.rs1_value == s.rs2_value;
				3'b001:  c = s.rs1_value != s.rs2_value;
				3'b100:  c = $signed(s.rs1_value) < $signed(s.rs2_value);
				3'b101:  c = $signed(s.rs1_value) >= $signed(s.rs2_value);
				3'b110:  c = s.rs1_value < s.rs2_value;
				3'b111:  c = s.rs1_value >= s.rs2_value;
				default: c = 1'b0;
			endcase
			e.take_branch = s.uncond_branch | (s.cond_branch & c);
			e.br_target   = a + b;
		end else begin
			case (s.alu_func)
				ex_pkg::ALU_SUB:  v = a - b;
				ex_pkg::ALU_AND:  v = a & b;
				ex_pkg::ALU_OR:   v = a | b;
				ex_pkg::ALU_XOR:  v = a ^ b;
				ex_pkg::ALU_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				ex_pkg::ALU_SLTU: v = (a < b) ? 32'd1 : 32'd0;
				ex_pkg::ALU_SLL:  v = a << b[4:0];
				ex_pkg::ALU_SRL:  v = a >> b[4:0];
				ex_pkg::ALU_SRA:  v = ex_pkg::xlen_t'($signed(a) >>> b[4:0]);
				default:          v = a + b;
			endcase
			if (s.uncond_branch) begin
				e.result      = s.npc;  // link value
				e.take_branch = 1'b1;
				e.br_target   = a + b;
			end else
				e.result = v;
		end
		return e;
	endfunction

	task automatic add_alu(input ex_pkg::alu_func_e f, input ex_pkg::opa_sel_e a,
			input ex_pkg::opb_sel_e b);
		ex_pkg::issue_slot_t s;
		s          = random_slot(ex_pkg::UNIT_ALU);
		s.alu_func = f;
		s.opa_sel  = a;
		s.opb_sel  = b;
		stim.push_back(s);
	endtask

	task automatic add_jump(input ex_pkg::opa_sel_e a, input ex_pkg::opb_sel_e b);
		add_alu(ex_pkg::ALU_ADD, a, b);
		stim[stim.size() - 1].uncond_branch = 1'b1;
	endtask

	task automatic add_mult(input ex_pkg::mult_func_e f);
		ex_pkg::issue_slot_t s;
		s           = random_slot(ex_pkg::UNIT_MULT);
		s.mult_func = f;
		stim.push_back(s);
	endtask

	task automatic add_branch(input logic [2:0] f3);
		ex_pkg::issue_slot_t s;
		s             = random_slot(ex_pkg::UNIT_BRANCH);
		s.inst[14:12] = f3;
		s.cond_branch = 1'b1;
		s.opa_sel     = ex_pkg::OPA_IS_PC;
		s.opb_sel     = ex_pkg::OPB_IS_B_IMM;
		stim.push_back(s);
	endtask

	task automatic set_operands(input ex_pkg::xlen_t r1, input ex_pkg::xlen_t r2);
		stim[stim.size() - 1].rs1_value = r1;
		stim[stim.size() - 1].rs2_value = r2;
	endtask

	task automatic build_table();
		// ALU functions over every operand choice
		add_alu(ex_pkg::ALU_ADD, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		add_alu(ex_pkg::ALU_SUB, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		add_alu(ex_pkg::ALU_AND, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_I_IMM);
		add_alu(ex_pkg::ALU_OR, ex_pkg::OPA_IS_PC, ex_pkg::OPB_IS_S_IMM);
		add_alu(ex_pkg::ALU_XOR, ex_pkg::OPA_IS_NPC, ex_pkg::OPB_IS_B_IMM);
		add_alu(ex_pkg::ALU_SLT, ex_pkg::OPA_IS_ZERO, ex_pkg::OPB_IS_U_IMM);
		add_alu(ex_pkg::ALU_SLTU, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_J_IMM);
		add_alu(ex_pkg::ALU_SLL, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		add_alu(ex_pkg::ALU_SRL, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_I_IMM);
		add_alu(ex_pkg::ALU_SRA, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		add_alu(ex_pkg::ALU_SLT, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		set_operands(32'h8000_0000, 32'h0000_0001);
		add_alu(ex_pkg::ALU_SRA, ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		set_operands(32'h8000_0000, 32'd31);
		// four pairs of multiplies back to back
		add_mult(ex_pkg::MUL);
		add_mult(ex_pkg::MULH);
		add_mult(ex_pkg::MULHSU);
		add_mult(ex_pkg::MULHU);
		add_mult(ex_pkg::MULH);
		set_operands(32'hffff_ffff, 32'hffff_ffff);
		add_mult(ex_pkg::MULHU);
		set_operands(32'hffff_ffff, 32'hffff_ffff);
		add_mult(ex_pkg::MULHSU);
		set_operands(32'h8000_0000, 32'hffff_ffff);
		add_mult(ex_pkg::MUL);
		set_operands(32'h8000_0000, 32'h8000_0000);
		// branch conditions followed by jal and jalr
		add_branch(3'b000);
		set_operands(32'h1234_5678, 32'h1234_5678);
		add_branch(3'b001);
		add_branch(3'b100);
		add_branch(3'b101);
		add_branch(3'b110);
		add_branch(3'b111);
		add_branch(3'b000);
		add_branch(3'b100);
		set_operands(32'hffff_fff0, 32'h0000_0010);
		add_branch(3'b010);  // not a branch code
		add_jump(ex_pkg::OPA_IS_PC, ex_pkg::OPB_IS_J_IMM);
		add_jump(ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_I_IMM);
		add_branch(3'b001);
		stim[stim.size() - 1].dest_tag = '0;  // no register write
		// mixed filler for the stall phase
		for (int k = 0; k < 16; k++) begin
			if (k % 3 == 0)
				add_mult(ex_pkg::mult_func_e'(k % 4));
			else
				add_alu(ex_pkg::alu_func_e'(k % 10), ex_pkg::OPA_IS_RS1, ex_pkg::OPB_IS_RS2);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking

	task automatic report_mismatch(input string name, input ex_pkg::xlen_t got,
			input ex_pkg::xlen_t want);
		$display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
		value_errors++;
	endtask

	task automatic check_result(input ex_pkg::complete_t got, input int slot);
		ex_pkg::complete_t want;
		want = expected[got.dest_tag];
		assert (tag_used[got.dest_tag]) else begin
			$display("unknown tag %0d on complete[%0d] at %0t ns", got.dest_tag, slot, $time);
			other_errors++;
		end
		seen[got.dest_tag]++;
		if (seen[got.dest_tag] == 1)
			distinct++;
		assert (seen[got.dest_tag] == 1) else begin
			$display("tag %0d delivered again at %0t ns", got.dest_tag, $time);
			other_errors++;
		end
		assert (got.result == want.result) else
			report_mismatch($sformatf("complete[%0d].result", slot), got.result, want.result);
		assert (got.take_branch == want.take_branch) else
			report_mismatch($sformatf("complete[%0d].take_branch", slot),
				ex_pkg::xlen_t'(got.take_branch), ex_pkg::xlen_t'(want.take_branch));
		assert (got.br_target == want.br_target) else
			report_mismatch($sformatf("complete[%0d].br_target", slot),
				got.br_target, want.br_target);
	endtask

	// one clock, driven on the falling edge and sampled 1 ns later
	task automatic run_cycle(input logic drain);
		int   popped;
		logic want_ready;
		logic want_wr;
		popped = 0;
		@(negedge clock);
		complete_ready = drain;
		for (int i = 0; i < N_WAY; i++) begin
			if (row < N_ROWS)
				issue[i] = stim[N_WAY * row + i];
			else
				issue[i] = '0;
		end
		#1;
		want_ready = (reserved + N_WAY <= Q_DEPTH);
		assert (issue_ready == want_ready) else
			report_mismatch("issue_ready", ex_pkg::xlen_t'(issue_ready),
				ex_pkg::xlen_t'(want_ready));
		for (int i = 0; i < N_WAY; i++) begin
			want_wr = complete[i].valid && (complete[i].dest_tag != '0);
			assert (reg_wr_en[i] == want_wr) else
				report_mismatch($sformatf("reg_wr_en[%0d]", i),
					ex_pkg::xlen_t'(reg_wr_en[i]), ex_pkg::xlen_t'(want_wr));
			if (complete[i].valid && drain) begin
				popped++;
				check_result(complete[i], i);
			end
		end
		for (int i = 1; i < N_WAY; i++)
			assert (!complete[i].valid || complete[i-1].valid) else begin
				$display("complete[%0d] valid above an empty entry at %0t ns", i, $time);
				other_errors++;
			end
		// every table row fills both slots
		if (issue_ready && row < N_ROWS) begin
			reserved += N_WAY;
			row++;
		end else if (!issue_ready)
			stall_seen = 1'b1;
		reserved -= popped;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		reset          = 1'b1;
		complete_ready = 1'b1;
		for (int i = 0; i < N_WAY; i++)
			issue[i] = '0;
		row          = 0;
		reserved     = 0;
		distinct     = 0;
		value_errors = 0;
		other_errors = 0;
		stall_seen   = 1'b0;
		build_table();
		assert (stim.size() == N_INST) else begin
			$display("table holds %0d instructions instead of %0d", stim.size(), N_INST);
			other_errors++;
		end
		foreach (stim[k]) begin
			tag_used[stim[k].dest_tag] = 1'b1;
			expected[stim[k].dest_tag] = model(stim[k]);
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (2) begin  // idle after reset
			@(negedge clock);
			#1;
			assert (issue_ready) else begin
				$display("issue_ready low after reset at %0t ns", $time);
				other_errors++;
			end
			for (int i = 0; i < N_WAY; i++)
				assert (!complete[i].valid) else begin
					$display("complete[%0d] valid before any issue at %0t ns", i, $time);
					other_errors++;
				end
		end
		while (row < N_ROWS / 2)
			run_cycle(1'b1);
		stall_seen = 1'b0;
		repeat (12)
			run_cycle(1'b0);  // head held until credit runs out
		assert (stall_seen) else begin
			$display("issue_ready never dropped while the queue was held");
			other_errors++;
		end
		while (row < N_ROWS || distinct < N_INST)
			run_cycle(1'b1);
		repeat (4)
			run_cycle(1'b1);  // catch late duplicates
		for (int t = 0; t < 64; t++)
			if (tag_used[t])
				assert (seen[t] == 1) else begin
					$display("tag %0d delivered %0d times", t, seen[t]);
					other_errors++;
				end
		$display("value errors %0d, other errors %0d, results %0d of %0d",
			value_errors, other_errors, distinct, N_INST);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* hdl/ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// execute stage top level
// one operand mux, ALU, branch unit and multiplier per issue slot;
// all results are collected in the completion queue, which hands
// out up to N_WAY results per cycle oldest first
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage #(
	parameter int N_WAY       = ex_pkg::N_WAY_DEF,
	parameter int MULT_STAGES = ex_pkg::MULT_STAGES_DEF,
	parameter int Q_DEPTH     = ex_pkg::Q_DEPTH_DEF
) (
	input  logic                clock,
	input  logic                reset,
	input  ex_pkg::issue_slot_t issue    [N_WAY],
	output logic                issue_ready,
	output ex_pkg::complete_t   complete [N_WAY],
	output logic [N_WAY-1:0]    reg_wr_en,
	input  logic                complete_ready
);

	ex_pkg::issue_slot_t slot_g     [N_WAY];  // valid gated by credit
	ex_pkg::complete_t   candidates [2*N_WAY];
	logic [N_WAY-1:0]    accepted;

	for (genvar i = 0; i < N_WAY; i++) begin : g_slot
		ex_pkg::xlen_t     opa, opb;
		ex_pkg::complete_t alu_entry, br_entry, mult_entry;

		always_comb begin
			slot_g[i]       = issue[i];
			slot_g[i].valid = issue[i].valid & issue_ready;
		end
		assign accepted[i] = slot_g[i].valid;

		operand_select operand_select_i (.slot(slot_g[i]), .opa(opa), .opb(opb));

		alu alu_i (.slot(slot_g[i]), .opa(opa), .opb(opb), .entry(alu_entry));

		branch_unit branch_unit_i (
			.slot (slot_g[i]),
			.opa  (opa),
			.opb  (opb),
			.entry(br_entry)
		);

		mult #(.MULT_STAGES(MULT_STAGES)) mult_i (
			.clock(clock),
			.reset(reset),
			.slot (slot_g[i]),
			.entry(mult_entry)
		);

		// multiplies are older than this cycle's issue, so they go first
		assign candidates[i]         = mult_entry;
		assign candidates[N_WAY + i] =
			(slot_g[i].unit == ex_pkg::UNIT_BRANCH) ? br_entry : alu_entry;

		assign reg_wr_en[i] = complete[i].valid && (complete[i].dest_tag != '0);
	end

	complete_queue #(
		.N_WAY  (N_WAY),
		.Q_DEPTH(Q_DEPTH)
	) complete_queue_i (
		.clock         (clock),
		.reset         (reset),
		.accepted      (accepted),
		.candidates    (candidates),
		.complete_ready(complete_ready),
		.complete      (complete),
		.issue_ready   (issue_ready)
	);

endmodule

/* hdl/complete_queue.sv */
//////////////////////////////////////////////////////////////////////
// completion queue between the execute units and writeback
// valid candidates are packed in at the tail each cycle, up to N_WAY
// oldest entries are shown at the head and popped on complete_ready;
// issue_ready is granted from a count of reserved slots so that
// everything in flight always has room
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module complete_queue #(
	parameter int N_WAY   = 2,
	parameter int Q_DEPTH = 8
) (
	input  logic              clock,
	input  logic              reset,
	input  logic [N_WAY-1:0]  accepted,
	input  ex_pkg::complete_t candidates [2*N_WAY],
	input  logic              complete_ready,
	output ex_pkg::complete_t complete   [N_WAY],
	output logic              issue_ready
);

	localparam int PW = $clog2(Q_DEPTH);
	localparam int CW = $clog2(Q_DEPTH + 2*N_WAY + 1); // room for sums

	typedef logic [PW-1:0] ptr_t;
	typedef logic [CW-1:0] cnt_t;

	ex_pkg::complete_t mem [Q_DEPTH];

	ptr_t head, tail;
	cnt_t count;     // entries held
	cnt_t reserved;  // accepted and not yet popped
	cnt_t n_push, n_pop, n_acc;
	ptr_t wr_idx [2*N_WAY];

	function automatic ptr_t wrap_add(input ptr_t base, input cnt_t offset);
		int sum;
		sum = (int'(base) + int'(offset)) % Q_DEPTH;
		return ptr_t'(sum);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// write side, compaction of valid candidates

	always_comb begin
		n_push = '0;
		for (int j = 0; j < 2*N_WAY; j++) begin
			wr_idx[j] = wrap_add(tail, n_push);
			if (candidates[j].valid)
				n_push = n_push + cnt_t'(1);
		end
	end

	always_ff @(posedge clock) begin
		for (int j = 0; j < 2*N_WAY; j++)
			if (candidates[j].valid)
				mem[wr_idx[j]] <= candidates[j];
	end

	//////////////////////////////////////////////////////////////////////
	// read side and credit

	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			if (cnt_t'(i) < count)
				complete[i] = mem[wrap_add(head, cnt_t'(i))];
			else
				complete[i] = '0;
		end
	end

	always_comb begin
		n_acc = '0;
		for (int i = 0; i < N_WAY; i++)
			n_acc = n_acc + cnt_t'(accepted[i]);
	end

	assign n_pop = !complete_ready ? '0 :
		(count > cnt_t'(N_WAY)) ? cnt_t'(N_WAY) : count;

	assign issue_ready = (reserved + cnt_t'(N_WAY)) <= cnt_t'(Q_DEPTH);

	always_ff @(posedge clock) begin
		if (reset) begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			reserved <= '0;
		end else begin
			head     <= wrap_add(head, n_pop);
			tail     <= wrap_add(tail, n_push);
			count    <= count + n_push - n_pop;
			reserved <= reserved + n_acc - n_pop;
		end
	end

endmodule

/* hdl/mult.sv */
//////////////////////////////////////////////////////////////////////
// pipelined RV32M multiplier for one issue slot
// operands sign extended to 64 bits, MULT_STAGES partial product
// stages, low or high word picked at the end; fully pipelined, so a
// new multiply may enter every cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mult #(
	parameter int MULT_STAGES = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  ex_pkg::issue_slot_t slot,
	output ex_pkg::complete_t   entry
);

	logic                   sign_mcand, sign_mplier;
	logic [MULT_STAGES:0]   done_chain;
	ex_pkg::tag_t           tag_chain     [MULT_STAGES+1];
	ex_pkg::dword_t         mcand_chain   [MULT_STAGES+1];
	ex_pkg::dword_t         mplier_chain  [MULT_STAGES+1];
	ex_pkg::dword_t         product_chain [MULT_STAGES+1];
	ex_pkg::mult_func_e     func_pipe     [MULT_STAGES];

	always_comb begin
		case (slot.mult_func)
			ex_pkg::MULHSU: {sign_mcand, sign_mplier} = 2'b10;
			ex_pkg::MULHU:  {sign_mcand, sign_mplier} = 2'b00;
			default:        {sign_mcand, sign_mplier} = 2'b11; // mul, mulh
		endcase
	end

	assign done_chain[0]    = slot.valid && (slot.unit == ex_pkg::UNIT_MULT);
	assign tag_chain[0]     = slot.dest_tag;
	assign mcand_chain[0]   = {{32{sign_mcand & slot.rs1_value[31]}}, slot.rs1_value};
	assign mplier_chain[0]  = {{32{sign_mplier & slot.rs2_value[31]}}, slot.rs2_value};
	assign product_chain[0] = '0;

	for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
		mult_stage #(
			.MULT_STAGES(MULT_STAGES)
		) mult_stage_i (
			.clock      (clock),
			.reset      (reset),
			.start      (done_chain[s]),
			.tag_in     (tag_chain[s]),
			.mcand_in   (mcand_chain[s]),
			.mplier_in  (mplier_chain[s]),
			.product_in (product_chain[s]),
			.done       (done_chain[s+1]),
			.tag_out    (tag_chain[s+1]),
			.mcand_out  (mcand_chain[s+1]),
			.mplier_out (mplier_chain[s+1]),
			.product_out(product_chain[s+1])
		);
	end

	// function travels alongside its operands
	always_ff @(posedge clock) begin
		func_pipe[0] <= slot.mult_func;
		for (int k = 1; k < MULT_STAGES; k++)
			func_pipe[k] <= func_pipe[k-1];
	end

	always_comb begin
		entry.valid       = done_chain[MULT_STAGES];
		entry.dest_tag    = tag_chain[MULT_STAGES];
		entry.take_branch = 1'b0;
		entry.br_target   = '0;
		if (func_pipe[MULT_STAGES-1] == ex_pkg::MUL)
			entry.result = product_chain[MULT_STAGES][31:0];
		else
			entry.result = product_chain[MULT_STAGES][63:32];
	end

endmodule

/* hdl/mult_stage.sv */
//////////////////////////////////////////////////////////////////////
// one partial product stage of the pipelined multiplier
// consumes MULT_BITS multiplier bits per stage, chained by mult
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mult_stage #(
	parameter int MULT_STAGES = 4
) (
	input  logic           clock,
	input  logic           reset,
	input  logic           start,
	input  ex_pkg::tag_t   tag_in,
	input  ex_pkg::dword_t mcand_in,
	input  ex_pkg::dword_t mplier_in,
	input  ex_pkg::dword_t product_in,
	output logic           done,
	output ex_pkg::tag_t   tag_out,
	output ex_pkg::dword_t mcand_out,
	output ex_pkg::dword_t mplier_out,
	output ex_pkg::dword_t product_out
);

	localparam int MULT_BITS = $bits(ex_pkg::dword_t) / MULT_STAGES;

	ex_pkg::dword_t partial;

	assign partial = ex_pkg::dword_t'(mplier_in[MULT_BITS-1:0]) * mcand_in;

	always_ff @(posedge clock) begin
		tag_out     <= tag_in;
		product_out <= product_in + partial;
		mcand_out   <= mcand_in << MULT_BITS;
		mplier_out  <= mplier_in >> MULT_BITS;
	end

	always_ff @(posedge clock) begin
		if (reset)
			done <= 1'b0;
		else
			done <= start;
	end

endmodule

/* hdl/branch_unit.sv */
//////////////////////////////////////////////////////////////////////
// branch condition test and target adder for one issue slot
// condition from funct3 on rs1/rs2, target is opa + opb
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_unit (
	input  ex_pkg::issue_slot_t slot,
	input  ex_pkg::xlen_t       opa,
	input  ex_pkg::xlen_t       opb,
	output ex_pkg::complete_t   entry
);

	logic       cond;
	logic [2:0] funct3;

	assign funct3 = slot.inst[14:12];

	always_comb begin
		case (funct3)
			3'b000:  cond = slot.rs1_value == slot.rs2_value;                  // beq
			3'b001:  cond = slot.rs1_value != slot.rs2_value;                  // bne
			3'b100:  cond = $signed(slot.rs1_value) < $signed(slot.rs2_value);  // blt
			3'b101:  cond = $signed(slot.rs1_value) >= $signed(slot.rs2_value); // bge
			3'b110:  cond = slot.rs1_value < slot.rs2_value;                   // bltu
			3'b111:  cond = slot.rs1_value >= slot.rs2_value;                  // bgeu
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		entry.valid       = slot.valid && (slot.unit == ex_pkg::UNIT_BRANCH);
		entry.dest_tag    = slot.dest_tag;
		entry.result      = '0;
		entry.take_branch = slot.uncond_branch | (slot.cond_branch & cond);
		entry.br_target   = opa + opb;
	end

endmodule

/* hdl/alu.sv */
//////////////////////////////////////////////////////////////////////
// integer ALU for one issue slot, purely combinational
// also shapes jump results: link value npc, target opa + opb
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu (
	input  ex_pkg::issue_slot_t slot,
	input  ex_pkg::xlen_t       opa,
	input  ex_pkg::xlen_t       opb,
	output ex_pkg::complete_t   entry
);

	ex_pkg::xlen_t alu_val;
	logic [4:0]    shamt;

	assign shamt = opb[4:0];

	always_comb begin
		case (slot.alu_func)
			ex_pkg::ALU_ADD:  alu_val = opa + opb;
			ex_pkg::ALU_SUB:  alu_val = opa - opb;
			ex_pkg::ALU_AND:  alu_val = opa & opb;
			ex_pkg::ALU_OR:   alu_val = opa | opb;
			ex_pkg::ALU_XOR:  alu_val = opa ^ opb;
			ex_pkg::ALU_SLT:  alu_val = {31'b0, $signed(opa) < $signed(opb)};
			ex_pkg::ALU_SLTU: alu_val = {31'b0, opa < opb};
			ex_pkg::ALU_SLL:  alu_val = opa << shamt;
			ex_pkg::ALU_SRL:  alu_val = opa >> shamt;
			ex_pkg::ALU_SRA:  alu_val = $signed(opa) >>> shamt;
			default:          alu_val = '0;
		endcase
	end

	always_comb begin
		entry.valid    = slot.valid && (slot.unit == ex_pkg::UNIT_ALU);
		entry.dest_tag = slot.dest_tag;
		if (slot.uncond_branch) begin
			// jal / jalr write the link address
			entry.result      = slot.npc;
			entry.take_branch = 1'b1;
			entry.br_target   = opa + opb;
		end else begin
			entry.result      = alu_val;
			entry.take_branch = 1'b0;
			entry.br_target   = '0;
		end
	end

endmodule

/* hdl/operand_select.sv */
//////////////////////////////////////////////////////////////////////
// operand muxes for one issue slot
// decodes the five immediate formats from the instruction word and
// picks operand A and B for the ALU and the branch target adder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_select (
	input  ex_pkg::issue_slot_t slot,
	output ex_pkg::xlen_t       opa,
	output ex_pkg::xlen_t       opb
);

	ex_pkg::xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;

	// sign extended immediates, bit 31 is always the sign
	assign i_imm = {{20{slot.inst[31]}}, slot.inst[31:20]};
	assign s_imm = {{20{slot.inst[31]}}, slot.inst[31:25], slot.inst[11:7]};
	assign b_imm = {{19{slot.inst[31]}}, slot.inst[31], slot.inst[7],
		slot.inst[30:25], slot.inst[11:8], 1'b0};
	assign u_imm = {slot.inst[31:12], 12'b0};
	assign j_imm = {{11{slot.inst[31]}}, slot.inst[31], slot.inst[19:12],
		slot.inst[20], slot.inst[30:21], 1'b0};

	always_comb begin
		case (slot.opa_sel)
			ex_pkg::OPA_IS_RS1:  opa = slot.rs1_value;
			ex_pkg::OPA_IS_NPC:  opa = slot.npc;
			ex_pkg::OPA_IS_PC:   opa = slot.pc;
			default:             opa = '0;  // OPA_IS_ZERO
		endcase
	end

	always_comb begin
		case (slot.opb_sel)
			ex_pkg::OPB_IS_RS2:   opb = slot.rs2_value;
			ex_pkg::OPB_IS_I_IMM: opb = i_imm;
			ex_pkg::OPB_IS_S_IMM: opb = s_imm;
			ex_pkg::OPB_IS_B_IMM: opb = b_imm;
			ex_pkg::OPB_IS_U_IMM: opb = u_imm;
			ex_pkg::OPB_IS_J_IMM: opb = j_imm;
			default:              opb = '0;  // unused encodings
		endcase
	end

endmodule

/* hdl/ex_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the execute stage of the out-of-order core
// word and tag widths, unit and function encodings, the issue slot
// and completion entry structs, and the top level parameter defaults
// referenced by scoped name from every design file
//////////////////////////////////////////////////////////////////////
package ex_pkg;

	// default sizing of the execute stage
	localparam int N_WAY_DEF       = 2;
	localparam int MULT_STAGES_DEF = 4;
	localparam int Q_DEPTH_DEF     = 8;

	typedef logic [31:0] xlen_t;   // data word
	typedef logic [63:0] dword_t;  // full width product
	typedef logic [5:0]  tag_t;    // physical dest tag, 0 = no write
	typedef logic [31:0] inst_t;   // raw instruction word

	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_MULT,
		UNIT_BRANCH
	} exec_unit_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {
		MUL,
		MULH,
		MULHSU,
		MULHU
	} mult_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_NPC,
		OPA_IS_PC,
		OPA_IS_ZERO
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_sel_e;

	//////////////////////////////////////////////////////////////////////
	// one issued instruction, branch condition comes from inst funct3
	typedef struct packed {
		logic       valid;
		exec_unit_e unit;
		alu_func_e  alu_func;
		mult_func_e mult_func;
		opa_sel_e   opa_sel;
		opb_sel_e   opb_sel;
		inst_t      inst;
		xlen_t      pc;
		xlen_t      npc;
		xlen_t      rs1_value;
		xlen_t      rs2_value;
		tag_t       dest_tag;
		logic       cond_branch;
		logic       uncond_branch;
	} issue_slot_t;

	// one finished result on its way to writeback
	typedef struct packed {
		logic  valid;
		tag_t  dest_tag;
		xlen_t result;
		logic  take_branch;
		xlen_t br_target;
	} complete_t;

endpackage
